/* compile.f */
+incdir+rtl
rtl/cache_addr_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_arrays.sv
rtl/hit_detect.sv
rtl/line_buffer.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary -f compile.f --top-module tb_dcache \
   -Mdir obj_dir -o tb_dcache_sim

./obj_dir/tb_dcache_sim > sim.log 2>&1

cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
   echo "run_sim: pass"
   exit 0
fi

echo "run_sim: fail"
exit 1

/* verification/tb_dcache.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_dcache;

   localparam int PERIOD_NS    = 40;
   localparam int NUM_TESTS    = 7;
   localparam int MAX_ACCESSES = 40;
   localparam int MAX_LAT      = 7;
   localparam int MAX_HOLD     = 16;
   // worst case per access covers a write-back, a full refill and a held response
   localparam int ACCESS_CYCLES = 4 + (`LINE_WORDS + 1) * (MAX_LAT + 2) + MAX_HOLD;
   localparam int WATCHDOG_NS   = NUM_TESTS * MAX_ACCESSES * ACCESS_CYCLES * PERIOD_NS;

   logic                  clk;
   logic                  reset;
   logic                  ce;
   logic                  we;
   logic                  resp_ready;
   cache_addr_pkg::addr_u addr;
   cache_addr_pkg::word_t wdata;
   logic [3:0]            wmask;
   logic                  resp_valid;
   cache_addr_pkg::word_t rdata;
   logic                  mem_ce;
   logic                  mem_we;
   logic [`ADDR_W-1:0]    mem_addr;
   cache_addr_pkg::line_t mem_wdata;
   cache_addr_pkg::word_t mem_rdata;
   logic                  mem_rdata_valid;
   logic                  mem_write_resp;
   logic [2:0]            mem_lat;

   cache_addr_pkg::word_t shadow [logic [`ADDR_W-1:0]];
   logic [31:0]           lfsr_state;
   int                    errors;
   int                    checks;
   int                    tests_run;
   int                    tests_failed;
   int                    mem_req_cycles;

   tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) clk_gen (
      .clk   (clk),
      .reset (reset)
   );

   dcache_top dut (
      .clk             (clk),
      .reset           (reset),
      .ce              (ce),
      .we              (we),
      .resp_ready      (resp_ready),
      .addr            (addr),
      .wdata           (wdata),
      .wmask           (wmask),
      .resp_valid      (resp_valid),
      .rdata           (rdata),
      .mem_ce          (mem_ce),
      .mem_we          (mem_we),
      .mem_addr        (mem_addr),
      .mem_wdata       (mem_wdata),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_write_resp  (mem_write_resp)
   );

   tb_mem_model mem (
      .clk             (clk),
      .mem_ce          (mem_ce),
      .mem_we          (mem_we),
      .mem_addr        (mem_addr),
      .mem_wdata       (mem_wdata),
      .latency         (mem_lat),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_write_resp  (mem_write_resp)
   );

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   // new memory latency after every answered word or write-back
   always @(posedge clk) begin
      if (mem_rdata_valid || mem_write_resp) begin
         mem_lat = 3'(random_bits(3));
      end
   end

   // cycles with a memory request open
   always @(negedge clk) begin
      if (mem_ce === 1'b1) begin
         mem_req_cycles++;
      end
   end

   function automatic cache_addr_pkg::word_t initial_word(input logic [`ADDR_W-1:0] a);
      return {a[7:0], a[31:8]} ^ (a * 32'h9e37_79b1);
   endfunction

   function automatic cache_addr_pkg::word_t shadow_word(input logic [`ADDR_W-1:0] a);
      if (shadow.exists(a)) begin
         return shadow[a];
      end
      return initial_word(a);
   endfunction

   task automatic shadow_write(input logic [`ADDR_W-1:0] a, input cache_addr_pkg::word_t wd,
                               input logic [3:0] m);
      cache_addr_pkg::word_t w;
      w = shadow_word(a);
      for (int b = 0; b < 4; b++) begin
         if (m[b]) begin
            w[b * 8 +: 8] = wd[b * 8 +: 8];
         end
      end
      shadow[a] = w;
   endtask

   function automatic logic [`ADDR_W-1:0] make_addr(input logic [`TAG_W-1:0] tag,
                                                   input logic [`INDEX_W-1:0] index,
                                                   input logic [`WORD_OFS_W-1:0] word);
      return {tag, index, word, 2'b00};
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error %s at %0t: got %h, expected %h", name, $time, got, exp);
         errors++;
      end
   endtask

   // one request with the response held for hold cycles before resp_ready
   task automatic access(input logic wr, input logic [`ADDR_W-1:0] a,
                         input cache_addr_pkg::word_t wd, input logic [3:0] m,
                         input int hold, output cache_addr_pkg::word_t rd);
      ce         = 1'b1;
      we         = wr;
      addr.flat  = a;
      wdata      = wd;
      wmask      = m;
      resp_ready = (hold == 0);
      @(negedge clk);
      while (!resp_valid) begin
         @(negedge clk);
      end
      rd = rdata;
      for (int i = 0; i < hold; i++) begin
         @(negedge clk);
         compare("resp_valid", {31'b0, resp_valid}, 32'd1);
         compare("rdata", rdata, rd);
      end
      resp_ready = 1'b1;
      @(negedge clk);
      ce = 1'b0;
      we = 1'b0;
   endtask

   task automatic load_check(input logic [`ADDR_W-1:0] a, input int hold);
      cache_addr_pkg::word_t rd;
      access(1'b0, a, '0, 4'h0, hold, rd);
      compare("rdata", rd, shadow_word(a));
   endtask

   task automatic store_word(input logic [`ADDR_W-1:0] a, input cache_addr_pkg::word_t wd,
                             input logic [3:0] m);
      cache_addr_pkg::word_t rd;
      access(1'b1, a, wd, m, 0, rd);
      shadow_write(a, wd, m);
   endtask

   task automatic report_test(input string name, input int start_errors);
      tests_run++;
      if (errors == start_errors) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - start_errors);
      end
   endtask

   task automatic test_reset_state();
      int start_errors;
      start_errors = errors;
      compare("resp_valid", {31'b0, resp_valid}, 32'd0);
      compare("mem_ce", {31'b0, mem_ce}, 32'd0);
      compare("mem_we", {31'b0, mem_we}, 32'd0);
      report_test("reset state", start_errors);
   endtask

   task automatic test_hit_after_miss();
      int start_errors;
      int refills;
      int reqs;
      start_errors = errors;
      refills = mem.refill_count;
      load_check(make_addr(24'h000100, 4'd1, 2'd2), 0);
      compare("refill count", mem.refill_count - refills, 1);
      reqs = mem_req_cycles;
      load_check(make_addr(24'h000100, 4'd1, 2'd0), 0);
      compare("mem_ce cycles", mem_req_cycles - reqs, 0);
      report_test("hit after miss", start_errors);
   endtask

   task automatic test_partial_store();
      int                 start_errors;
      int                 refills;
      logic [`ADDR_W-1:0] a;
      start_errors = errors;
      a = make_addr(24'h000200, 4'd2, 2'd1);
      load_check(a, 0);
      refills = mem.refill_count;
      store_word(a, 32'haabb_ccdd, 4'b0101);
      load_check(a, 0);
      compare("refill count", mem.refill_count - refills, 0);
      report_test("partial store", start_errors);
   endtask

   task automatic test_dirty_evict();
      int                 start_errors;
      int                 wbs;
      logic [`ADDR_W-1:0] x;
      start_errors = errors;
      x = make_addr(24'h000300, 4'd3, 2'd0);
      store_word(x, 32'h1234_5678, 4'b1011);
      wbs = mem.wb_count;
      load_check(make_addr(24'h000301, 4'd3, 2'd0), 0);
      load_check(make_addr(24'h000302, 4'd3, 2'd0), 0);
      compare("write-back count", mem.wb_count - wbs, 1);
      compare("mem_addr", mem.last_wb_addr, x);
      for (int w = 0; w < `LINE_WORDS; w++) begin
         compare("mem_wdata", mem.last_wb_line[w * `DATA_W +: `DATA_W], shadow_word(x + 4 * w));
      end
      load_check(x, 0);
      report_test("dirty eviction", start_errors);
   endtask

   task automatic test_lru_order();
      int                 start_errors;
      int                 wbs;
      int                 refills;
      int                 reqs;
      logic [`ADDR_W-1:0] a;
      logic [`ADDR_W-1:0] b;
      start_errors = errors;
      a = make_addr(24'h000400, 4'd4, 2'd0);
      b = make_addr(24'h000401, 4'd4, 2'd0);
      load_check(a, 0);
      load_check(b, 0);
      load_check(a, 0);
      wbs = mem.wb_count;
      load_check(make_addr(24'h000402, 4'd4, 2'd0), 0);
      compare("write-back count", mem.wb_count - wbs, 0);
      reqs = mem_req_cycles;
      load_check(a, 0);
      compare("mem_ce cycles", mem_req_cycles - reqs, 0);
      // b went out and comes back through a refill
      refills = mem.refill_count;
      load_check(b, 0);
      compare("refill count", mem.refill_count - refills, 1);
      report_test("lru order", start_errors);
   endtask

   task automatic test_back_pressure();
      int start_errors;
      start_errors = errors;
      load_check(make_addr(24'h000500, 4'd5, 2'd3), 1 + random_bits(4));
      load_check(make_addr(24'h000500, 4'd5, 2'd1), 1 + random_bits(4));
      report_test("back-pressure", start_errors);
   endtask

   // three sets with four tags each keep dirty evictions frequent
   task automatic test_random_mix();
      int                    start_errors;
      int                    set_ofs;
      logic [`ADDR_W-1:0]    a;
      cache_addr_pkg::word_t wd;
      start_errors = errors;
      for (int i = 0; i < MAX_ACCESSES; i++) begin
         set_ofs = random_bits(2) % 3;
         a = make_addr(24'h000600 + 24'(random_bits(2)), 4'(6 + set_ofs), 2'(random_bits(2)));
         if (random_bits(1) == 1) begin
            wd = random_bits(32);
            store_word(a, wd, 4'(random_bits(4)));
         end else begin
            load_check(a, 0);
         end
      end
      report_test("random mix", start_errors);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, a request never completed", WATCHDOG_NS);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      lfsr_state   = 32'h92d1_e7aa;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      ce           = 1'b0;
      we           = 1'b0;
      resp_ready   = 1'b1;
      addr.flat    = '0;
      wdata        = '0;
      wmask        = 4'h0;
      mem_lat      = 3'(random_bits(3));
      @(negedge reset);
      @(negedge clk);
      test_reset_state();
      test_hit_after_miss();
      test_partial_store();
      test_dirty_evict();
      test_lru_order();
      test_back_pressure();
      test_random_mix();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_mem_model (
   input  logic                  clk,
   input  logic                  mem_ce,
   input  logic                  mem_we,
   input  logic [`ADDR_W-1:0]    mem_addr,
   input  cache_addr_pkg::line_t mem_wdata,
   input  logic [2:0]            latency,
   output cache_addr_pkg::word_t mem_rdata,
   output logic                  mem_rdata_valid,
   output logic                  mem_write_resp
);

   cache_addr_pkg::word_t store [logic [`ADDR_W-1:0]];
   int                    refill_count;
   int                    wb_count;
   logic [`ADDR_W-1:0]    last_wb_addr;
   cache_addr_pkg::line_t last_wb_line;

   // contents before any write-back, every address bit mixed in
   function automatic cache_addr_pkg::word_t fill_word(input logic [`ADDR_W-1:0] a);
      return {a[7:0], a[31:8]} ^ (a * 32'h9e37_79b1);
   endfunction

   function automatic cache_addr_pkg::word_t read_word(input logic [`ADDR_W-1:0] a);
      if (store.exists(a)) begin
         return store[a];
      end
      return fill_word(a);
   endfunction

   task automatic answer_write_back();
      logic [`ADDR_W-1:0] base;
      base = mem_addr;
      for (int w = 0; w < `LINE_WORDS; w++) begin
         store[base + 4 * w] = mem_wdata[w * `DATA_W +: `DATA_W];
      end
      last_wb_addr = base;
      last_wb_line = mem_wdata;
      wb_count++;
      repeat (latency) @(negedge clk);
      mem_write_resp = 1'b1;
      @(negedge clk);
      mem_write_resp = 1'b0;
   endtask

   // one word per valid pulse, lowest address first
   task automatic answer_refill();
      logic [`ADDR_W-1:0] base;
      base = mem_addr;
      refill_count++;
      for (int w = 0; w < `LINE_WORDS; w++) begin
         repeat (latency) @(negedge clk);
         mem_rdata       = read_word(base + 4 * w);
         mem_rdata_valid = 1'b1;
         @(negedge clk);
         mem_rdata_valid = 1'b0;
      end
   endtask

   initial begin
      mem_rdata       = '0;
      mem_rdata_valid = 1'b0;
      mem_write_resp  = 1'b0;
      refill_count    = 0;
      wb_count        = 0;
      last_wb_addr    = '0;
      last_wb_line    = '0;
      forever begin
         @(negedge clk);
         if (mem_ce && mem_we) begin
            answer_write_back();
         end else if (mem_ce) begin
            answer_refill();
         end
      end
   end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release on a falling edge, clear of the sampling edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module dcache_top (
   input  logic                   clk,
   input  logic                   reset,
   input  bit                     ce,
   input  bit                     we,
   input  bit                     resp_ready,
   input  cache_addr_pkg::addr_u  addr,
   input  cache_addr_pkg::word_t  wdata,
   input  logic [3:0]             wmask,
   output logic                   resp_valid,
   output cache_addr_pkg::word_t  rdata,
   output logic                   mem_ce,
   output logic                   mem_we,
   output logic [`ADDR_W-1:0]     mem_addr,
   output cache_addr_pkg::line_t  mem_wdata,
   input  cache_addr_pkg::word_t  mem_rdata,
   input  logic                   mem_rdata_valid,
   input  logic                   mem_write_resp
);

   logic [`TAG_W-1:0]     tag0;
   logic [`TAG_W-1:0]     tag1;
   cache_addr_pkg::line_t line0;
   cache_addr_pkg::line_t line1;
   logic [1:0]            valid;
   logic [1:0]            dirty;
   cache_ctrl_pkg::way_t  lru;
   logic                  hit;
   cache_ctrl_pkg::way_t  hit_way;
   cache_addr_pkg::line_t hit_line;
   logic                  victim_dirty;
   logic [`ADDR_W-1:0]    victim_addr;
   cache_addr_pkg::line_t victim_line;
   cache_addr_pkg::line_t merged_line;
   cache_addr_pkg::addr_u line_base;
   cache_ctrl_pkg::way_t  wr_way;
   cache_ctrl_pkg::way_t  wr_lru;
   logic                  line_we;
   logic                  dirty_we;
   logic                  lru_we;
   logic                  wr_dirty;
   logic                  refill_shift;
   logic                  refill_clear;
   logic                  victim_load;
   logic                  use_refill;

   // refill starts at the line boundary of the request
   always_comb begin
      line_base            = addr;
      line_base.f.word     = '0;
      line_base.f.byte_ofs = '0;
   end

   cache_arrays u_arrays (
      .clk      (clk),
      .reset    (reset),
      .index    (addr.f.index),
      .wr_way   (wr_way),
      .line_we  (line_we),
      .dirty_we (dirty_we),
      .lru_we   (lru_we),
      .wr_tag   (addr.f.tag),
      .wr_line  (merged_line),
      .wr_dirty (wr_dirty),
      .wr_lru   (wr_lru),
      .tag0     (tag0),
      .tag1     (tag1),
      .line0    (line0),
      .line1    (line1),
      .valid    (valid),
      .dirty    (dirty),
      .lru      (lru)
   );

   hit_detect u_hit (
      .tag          (addr.f.tag),
      .index        (addr.f.index),
      .tag0         (tag0),
      .tag1         (tag1),
      .valid        (valid),
      .dirty        (dirty),
      .lru          (lru),
      .line0        (line0),
      .line1        (line1),
      .hit          (hit),
      .hit_way      (hit_way),
      .hit_line     (hit_line),
      .victim_dirty (victim_dirty),
      .victim_addr  (victim_addr),
      .victim_line  (victim_line)
   );

   line_buffer u_lbuf (
      .clk            (clk),
      .reset          (reset),
      .refill_word    (mem_rdata),
      .refill_shift   (refill_shift),
      .refill_clear   (refill_clear),
      .victim_load    (victim_load),
      .victim_line_in (victim_line),
      .hit_line       (hit_line),
      .use_refill     (use_refill),
      .we             (we),
      .wdata          (wdata),
      .wmask          (wmask),
      .word           (addr.f.word),
      .wb_line        (mem_wdata),
      .merged_line    (merged_line),
      .rdata          (rdata)
   );

   dcache_ctrl u_ctrl (
      .clk             (clk),
      .reset           (reset),
      .ce              (ce),
      .we              (we),
      .resp_ready      (resp_ready),
      .hit             (hit),
      .hit_way         (hit_way),
      .lru             (lru),
      .victim_dirty    (victim_dirty),
      .victim_addr     (victim_addr),
      .line_base       (line_base.flat),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_write_resp  (mem_write_resp),
      .resp_valid      (resp_valid),
      .mem_ce          (mem_ce),
      .mem_we          (mem_we),
      .mem_addr        (mem_addr),
      .wr_way          (wr_way),
      .line_we         (line_we),
      .dirty_we        (dirty_we),
      .lru_we          (lru_we),
      .wr_dirty        (wr_dirty),
      .wr_lru          (wr_lru),
      .refill_shift    (refill_shift),
      .refill_clear    (refill_clear),
      .victim_load     (victim_load),
      .use_refill      (use_refill)
   );

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module dcache_ctrl (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   ce,
   input  logic                   we,
   input  logic                   resp_ready,
   input  logic                   hit,
   input  cache_ctrl_pkg::way_t   hit_way,
   input  cache_ctrl_pkg::way_t   lru,
   input  logic                   victim_dirty,
   input  logic [`ADDR_W-1:0]     victim_addr,
   input  logic [`ADDR_W-1:0]     line_base,
   input  logic                   mem_rdata_valid,
   input  logic                   mem_write_resp,
   output logic                   resp_valid,
   output logic                   mem_ce,
   output logic                   mem_we,
   output logic [`ADDR_W-1:0]     mem_addr,
   output cache_ctrl_pkg::way_t   wr_way,
   output logic                   line_we,
   output logic                   dirty_we,
   output logic                   lru_we,
   output logic                   wr_dirty,
   output cache_ctrl_pkg::way_t   wr_lru,
   output logic                   refill_shift,
   output logic                   refill_clear,
   output logic                   victim_load,
   output logic                   use_refill
);

   localparam int CNT_W = $clog2(`LINE_WORDS) + 1;

   cache_ctrl_pkg::cache_state_e state;
   cache_ctrl_pkg::cache_state_e next_state;
   logic [CNT_W-1:0]             refill_cnt;
   logic                         refill_done;
   logic                         in_lookup;
   logic                         in_refill;
   logic                         handshake;
   logic                         miss;

   assign in_lookup   = (state == cache_ctrl_pkg::st_lookup);
   assign in_refill   = (state == cache_ctrl_pkg::st_refill);
   assign refill_done = (refill_cnt == CNT_W'(`LINE_WORDS));
   assign miss        = in_lookup & ~hit;

   always_comb begin
      next_state = state;
      case (state)
         cache_ctrl_pkg::st_idle: begin
            if (ce) begin
               next_state = cache_ctrl_pkg::st_lookup;
            end
         end
         cache_ctrl_pkg::st_lookup: begin
            if (hit) begin
               if (resp_ready) begin
                  next_state = cache_ctrl_pkg::st_idle;
               end
            end else if (victim_dirty) begin
               next_state = cache_ctrl_pkg::st_write_back;
            end else begin
               next_state = cache_ctrl_pkg::st_refill;
            end
         end
         cache_ctrl_pkg::st_write_back: begin
            if (mem_write_resp) begin
               next_state = cache_ctrl_pkg::st_refill;
            end
         end
         cache_ctrl_pkg::st_refill: begin
            if (refill_done && resp_ready) begin
               next_state = cache_ctrl_pkg::st_idle;
            end
         end
         default: next_state = cache_ctrl_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= cache_ctrl_pkg::st_idle;
      end else begin
         state <= next_state;
      end
   end

   // refill word counter, idle outside refill
   always_ff @(posedge clk) begin
      if (reset || !in_refill) begin
         refill_cnt <= '0;
      end else if (refill_shift) begin
         refill_cnt <= refill_cnt + 1'b1;
      end
   end

   assign refill_shift = in_refill & mem_rdata_valid & ~refill_done;
   assign refill_clear = miss;
   assign victim_load  = miss & victim_dirty;
   assign use_refill   = in_refill;

   // memory side, one line-wide write or a word-by-word read
   assign mem_ce   = (state == cache_ctrl_pkg::st_write_back) | (in_refill & ~refill_done);
   assign mem_we   = (state == cache_ctrl_pkg::st_write_back);
   assign mem_addr = mem_we ? victim_addr : line_base;

   assign resp_valid = (in_lookup & hit) | (in_refill & refill_done);
   assign handshake  = resp_valid & resp_ready;

   // array updates only at the handshake edge
   assign wr_way   = in_refill ? lru : hit_way;
   assign line_we  = handshake & (in_refill | we);
   assign dirty_we = line_we;
   assign wr_dirty = we;
   assign lru_we   = handshake;
   assign wr_lru   = ~wr_way;

endmodule

/* rtl/line_buffer.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module line_buffer (
   input  logic                     clk,
   input  logic                     reset,
   input  cache_addr_pkg::word_t    refill_word,
   input  logic                     refill_shift,
   input  logic                     refill_clear,
   input  logic                     victim_load,
   input  cache_addr_pkg::line_t    victim_line_in,
   input  cache_addr_pkg::line_t    hit_line,
   input  logic                     use_refill,
   input  logic                     we,
   input  cache_addr_pkg::word_t    wdata,
   input  logic [`DATA_W/8-1:0]     wmask,
   input  logic [`WORD_OFS_W-1:0]   word,
   output cache_addr_pkg::line_t    wb_line,
   output cache_addr_pkg::line_t    merged_line,
   output cache_addr_pkg::word_t    rdata
);

   cache_addr_pkg::line_t refill_line;
   cache_addr_pkg::line_t base_line;

   // refill words arrive lowest address first, enter at the top
   always_ff @(posedge clk) begin
      if (reset || refill_clear) begin
         refill_line <= '0;
      end else if (refill_shift) begin
         refill_line <= {refill_word, refill_line[`LINE_W-1:`DATA_W]};
      end
   end

   // dirty victim held for the whole write-back
   always_ff @(posedge clk) begin
      if (victim_load) begin
         wb_line <= victim_line_in;
      end
   end

   assign base_line = use_refill ? refill_line : hit_line;

   // byte merge of store data into the addressed word
   always_comb begin
      merged_line = base_line;
      if (we) begin
         for (int b = 0; b < `DATA_W / 8; b++) begin
            if (wmask[b]) begin
               merged_line[word * `DATA_W + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
         end
      end
   end

   // load data comes from the line before any merge
   assign rdata = base_line[word * `DATA_W +: `DATA_W];

endmodule

/* rtl/hit_detect.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module hit_detect (
   input  logic [`TAG_W-1:0]      tag,
   input  logic [`INDEX_W-1:0]    index,
   input  logic [`TAG_W-1:0]      tag0,
   input  logic [`TAG_W-1:0]      tag1,
   input  logic [1:0]             valid,
   input  logic [1:0]             dirty,
   input  cache_ctrl_pkg::way_t   lru,
   input  cache_addr_pkg::line_t  line0,
   input  cache_addr_pkg::line_t  line1,
   output logic                   hit,
   output cache_ctrl_pkg::way_t   hit_way,
   output cache_addr_pkg::line_t  hit_line,
   output logic                   victim_dirty,
   output logic [`ADDR_W-1:0]     victim_addr,
   output cache_addr_pkg::line_t  victim_line
);

   logic                  hit0;
   logic                  hit1;
   cache_addr_pkg::addr_u victim_base;

   assign hit0 = valid[0] && (tag0 == tag);
   assign hit1 = valid[1] && (tag1 == tag);

   assign hit      = hit0 | hit1;
   assign hit_way  = hit1;
   assign hit_line = hit1 ? line1 : line0;

   // lru bit names the way to replace
   assign victim_dirty = valid[lru] & dirty[lru];
   assign victim_line  = lru ? line1 : line0;

   // line address of the victim, word and byte offsets zero
   always_comb begin
      victim_base.f.tag      = lru ? tag1 : tag0;
      victim_base.f.index    = index;
      victim_base.f.word     = '0;
      victim_base.f.byte_ofs = '0;
   end

   assign victim_addr = victim_base.flat;

endmodule

/* rtl/cache_arrays.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_arrays (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`INDEX_W-1:0]    index,
   input  cache_ctrl_pkg::way_t   wr_way,
   input  logic                   line_we,
   input  logic                   dirty_we,
   input  logic                   lru_we,
   input  logic [`TAG_W-1:0]      wr_tag,
   input  cache_addr_pkg::line_t  wr_line,
   input  logic                   wr_dirty,
   input  cache_ctrl_pkg::way_t   wr_lru,
   output logic [`TAG_W-1:0]      tag0,
   output logic [`TAG_W-1:0]      tag1,
   output cache_addr_pkg::line_t  line0,
   output cache_addr_pkg::line_t  line1,
   output logic [1:0]             valid,
   output logic [1:0]             dirty,
   output cache_ctrl_pkg::way_t   lru
);

   logic [`TAG_W-1:0]     tag_mem  [2][`NUM_SETS];
   cache_addr_pkg::line_t line_mem [2][`NUM_SETS];
   logic [1:0]            valid_mem [`NUM_SETS];
   logic [1:0]            dirty_mem [`NUM_SETS];
   cache_ctrl_pkg::way_t  lru_mem   [`NUM_SETS];

   // tag and data storage, registered read port
   always_ff @(posedge clk) begin
      if (line_we) begin
         tag_mem[wr_way][index]  <= wr_tag;
         line_mem[wr_way][index] <= wr_line;
      end
      tag0  <= tag_mem[0][index];
      tag1  <= tag_mem[1][index];
      line0 <= line_mem[0][index];
      line1 <= line_mem[1][index];
   end

   // state bits, cleared for every set on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `NUM_SETS; s++) begin
            valid_mem[s] <= 2'b00;
            dirty_mem[s] <= 2'b00;
            lru_mem[s]   <= 1'b0;
         end
         valid <= 2'b00;
         dirty <= 2'b00;
         lru   <= 1'b0;
      end else begin
         // a line write always leaves the way valid
         if (line_we) begin
            valid_mem[index][wr_way] <= 1'b1;
         end
         if (dirty_we) begin
            dirty_mem[index][wr_way] <= wr_dirty;
         end
         if (lru_we) begin
            lru_mem[index] <= wr_lru;
         end
         valid <= valid_mem[index];
         dirty <= dirty_mem[index];
         lru   <= lru_mem[index];
      end
   end

endmodule

/* rtl/cache_ctrl_pkg.sv */
`include "cache_params.svh"

package cache_ctrl_pkg;

   // way number, two ways
   typedef logic way_t;

   // controller states
   typedef enum logic [1:0] {
      st_idle,
      st_lookup,
      st_write_back,
      st_refill
   } cache_state_e;

endpackage

/* rtl/cache_addr_pkg.sv */
`include "cache_params.svh"

package cache_addr_pkg;

   // one cpu word
   typedef logic [`DATA_W-1:0] word_t;

   // one full cache line, word 0 in the low bits
   typedef logic [`LINE_W-1:0] line_t;

   // field view of a bus address
   typedef struct packed {
      logic [`TAG_W-1:0]      tag;
      logic [`INDEX_W-1:0]    index;
      logic [`WORD_OFS_W-1:0] word;
      logic [`BYTE_OFS_W-1:0] byte_ofs;
   } addr_fields_t;

   // same address word, flat or split into fields
   typedef union packed {
      logic [`ADDR_W-1:0] flat;
      addr_fields_t       f;
   } addr_u;

endpackage

/* rtl/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// bus and word widths
`define ADDR_W 32
`define DATA_W 32

// cache geometry, two ways per set
`define LINE_WORDS 4
`define NUM_SETS 16
`define LINE_W (`DATA_W * `LINE_WORDS)

// address split, low to high
`define BYTE_OFS_W 2
`define WORD_OFS_W 2
`define INDEX_W 4
`define TAG_W 24

`endif
